/* flist.f */
design/kvs_ctrl_pkg.sv
design/kvs_mem_pkg.sv
design/ctrl_regs.sv
design/run_control.sv
design/addr_translate.sv
design/kvs_shell_top.sv
sim/kvs_shell_tb.sv

/* Makefile */
# Verilator build and run of the kvs shell testbench

VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= kvs_shell_tb
RTL_TOP    ?= kvs_shell_top
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --timing --assert -Wall
SIM_ARGS   ?=

SRCS    := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# exit status of the simulation binary is the test result
run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

/* sim/kvs_shell_tb.sv */
`timescale 1ns/100ps

module kvs_shell_tb;
  import kvs_ctrl_pkg::*;
  import kvs_mem_pkg::*;

  localparam int reset_cycles  = 16;
  localparam int n_xlat        = 8;  // requests per path in the translation test
  localparam int hold_cycles   = 4;
  localparam int access_cycles = 5;  // rough length of one control bus access
  // rough cost of each test in clock cycles
  localparam int test_cycles = access_cycles + 2    // reset state
    + 15 * access_cycles                            // register access
    + 5 * access_cycles + 64 + 4                    // run sequencing
    + 4 * access_cycles + n_xlat * 4 * 4 + 8        // translation
    + 3 * 4 + hold_cycles + 8;                      // back-pressure
  localparam int watchdog_cycles = reset_cycles + test_cycles + 2000;

  logic ap_clk;
  logic ap_rst_n;
  logic s_axi_control_awvalid, s_axi_control_awready, s_axi_control_wvalid, s_axi_control_wready;
  logic s_axi_control_bvalid, s_axi_control_bready, s_axi_control_arvalid, s_axi_control_arready;
  logic s_axi_control_rvalid, s_axi_control_rready;
  logic [ctrl_addr_w-1:0] s_axi_control_awaddr, s_axi_control_araddr;
  logic [ctrl_data_w-1:0] s_axi_control_wdata, s_axi_control_rdata;
  logic [ctrl_strb_w-1:0] s_axi_control_wstrb;
  logic [1:0] s_axi_control_bresp, s_axi_control_rresp;
  logic c0_aw_local_valid, c0_aw_local_ready, c0_ar_local_valid, c0_ar_local_ready;
  logic c1_aw_local_valid, c1_aw_local_ready, c1_ar_local_valid, c1_ar_local_ready;
  logic [local_addr_w-1:0] c0_aw_local_addr, c0_ar_local_addr, c1_aw_local_addr, c1_ar_local_addr;
  logic c0_awvalid, c0_awready, c0_arvalid, c0_arready;
  logic c1_awvalid, c1_awready, c1_arvalid, c1_arready;
  logic [host_addr_w-1:0] c0_awaddr, c0_araddr, c1_awaddr, c1_araddr;
  logic core_run;

  integer seed = 32'hcf336d37;
  logic [63:0] ptr_model [2];   // pointers as last programmed
  logic [63:0] exp_q [4][$];    // path 0 c0 aw, 1 c0 ar, 2 c1 aw, 3 c1 ar
  logic [63:0] got_q [4][$];
  string path_name [4] = '{"c0_awaddr", "c0_araddr", "c1_awaddr", "c1_araddr"};

  kvs_shell_top kvs_shell_top_inst (.*);

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  ////////////////////////////////////////////////////////////
  // checking and reporting
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge ap_clk);
    abort_run("watchdog expired before the tests finished");
  end

  // host side transfers seen mid-cycle
  always @(negedge ap_clk) begin
    if (c0_awvalid && c0_awready) got_q[0].push_back(c0_awaddr);
    if (c0_arvalid && c0_arready) got_q[1].push_back(c0_araddr);
    if (c1_awvalid && c1_awready) got_q[2].push_back(c1_awaddr);
    if (c1_arvalid && c1_arready) got_q[3].push_back(c1_araddr);
  end

  function automatic logic [31:0] ctrl_word(input logic start, input logic done, input logic idle);
    logic [31:0] w;
    w = '0;
    w[ctrl_start_bit] = start;
    w[ctrl_done_bit]  = done;
    w[ctrl_idle_bit]  = idle;
    return w;
  endfunction

  function automatic logic [local_addr_w-1:0] rand_local_addr();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[local_addr_w-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // bus helpers
  ////////////////////////////////////////////////////////////

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data, input logic [3:0] strb);
    @(posedge ap_clk);
    s_axi_control_awvalid <= 1'b1;
    s_axi_control_awaddr  <= addr;
    s_axi_control_wvalid  <= 1'b1;
    s_axi_control_wdata   <= data;
    s_axi_control_wstrb   <= strb;
    do @(negedge ap_clk); while (!(s_axi_control_awready && s_axi_control_wready));
    @(posedge ap_clk);
    s_axi_control_awvalid <= 1'b0;
    s_axi_control_wvalid  <= 1'b0;
    s_axi_control_bready  <= 1'b1;
    do @(negedge ap_clk); while (!s_axi_control_bvalid);
    expect_eq("s_axi_control_bresp", s_axi_control_bresp, resp_okay);
    @(posedge ap_clk);
    s_axi_control_bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, input logic [31:0] exp);
    @(posedge ap_clk);
    s_axi_control_arvalid <= 1'b1;
    s_axi_control_araddr  <= addr;
    do @(negedge ap_clk); while (!s_axi_control_arready);
    @(posedge ap_clk);
    s_axi_control_arvalid <= 1'b0;
    s_axi_control_rready  <= 1'b1;
    do @(negedge ap_clk); while (!s_axi_control_rvalid);
    expect_eq($sformatf("s_axi_control_rdata at 0x%03h", addr), s_axi_control_rdata, exp);
    expect_eq("s_axi_control_rresp", s_axi_control_rresp, resp_okay);
    @(posedge ap_clk);
    s_axi_control_rready <= 1'b0;
  endtask

  task automatic drive_local(input int path, input logic v, input logic [local_addr_w-1:0] a);
    case (path)
      0: begin
        c0_aw_local_valid <= v;
        c0_aw_local_addr  <= a;
      end
      1: begin
        c0_ar_local_valid <= v;
        c0_ar_local_addr  <= a;
      end
      2: begin
        c1_aw_local_valid <= v;
        c1_aw_local_addr  <= a;
      end
      default: begin
        c1_ar_local_valid <= v;
        c1_ar_local_addr  <= a;
      end
    endcase
  endtask

  function automatic logic local_ready(input int path);
    case (path)
      0: return c0_aw_local_ready;
      1: return c0_ar_local_ready;
      2: return c1_aw_local_ready;
      default: return c1_ar_local_ready;
    endcase
  endfunction

  task automatic send_local(input int path, input logic [local_addr_w-1:0] addr);
    logic [63:0] exp_addr;
    exp_addr = ptr_model[path / 2] + 64'(addr); // wraps at 2^64
    @(posedge ap_clk);
    drive_local(path, 1'b1, addr);
    do @(negedge ap_clk); while (!local_ready(path));
    @(posedge ap_clk);
    drive_local(path, 1'b0, addr);
    exp_q[path].push_back(exp_addr);
  endtask

  task automatic compare_host_addrs();
    for (int p = 0; p < 4; p++) begin
      while (got_q[p].size() < exp_q[p].size()) @(negedge ap_clk);
      while (exp_q[p].size() > 0) begin
        expect_eq(path_name[p], got_q[p].pop_front(), exp_q[p].pop_front());
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic check_reset_values();
    @(negedge ap_clk);
    expect_eq("s_axi_control_bvalid", s_axi_control_bvalid, 1'b0);
    expect_eq("s_axi_control_rvalid", s_axi_control_rvalid, 1'b0);
    expect_eq("s_axi_control_awready", s_axi_control_awready, 1'b1);
    expect_eq("s_axi_control_wready", s_axi_control_wready, 1'b1);
    expect_eq("s_axi_control_arready", s_axi_control_arready, 1'b1);
    expect_eq("c0_awvalid", c0_awvalid, 1'b0);
    expect_eq("c0_arvalid", c0_arvalid, 1'b0);
    expect_eq("c1_awvalid", c1_awvalid, 1'b0);
    expect_eq("c1_arvalid", c1_arvalid, 1'b0);
    expect_eq("core_run", core_run, 1'b0);
    axi_read(reg_ctrl, ctrl_word(1'b0, 1'b0, 1'b1));
  endtask

  task automatic access_registers();
    logic [11:0] offs [6];
    logic [31:0] vals [6];
    logic [31:0] upd;
    offs = '{reg_cycles_lo, reg_cycles_hi, reg_ptr0_lo, reg_ptr0_hi, reg_ptr1_lo, reg_ptr1_hi};
    for (int i = 0; i < 6; i++) begin
      vals[i] = $random(seed);
      axi_write(offs[i], vals[i], 4'hf);
    end
    for (int i = 0; i < 6; i++) axi_read(offs[i], vals[i]);
    upd = $random(seed);
    axi_write(reg_ptr0_lo, upd, 4'b0101); // bytes 0 and 2 only
    axi_read(reg_ptr0_lo, {vals[2][31:24], upd[23:16], vals[2][15:8], upd[7:0]});
    axi_read(12'h040, 32'h0);
  endtask

  task automatic time_one_run();
    logic [31:0] len;
    logic [31:0] ran;
    len = ($random(seed) & 32'h3f) + 1;
    axi_write(reg_cycles_lo, len, 4'hf);
    axi_write(reg_cycles_hi, 32'h0, 4'hf);
    axi_write(reg_ctrl, ctrl_word(1'b1, 1'b0, 1'b0), 4'hf);
    do @(negedge ap_clk); while (!core_run);
    ran = 0;
    while (core_run) begin
      ran++;
      @(negedge ap_clk);
    end
    expect_eq("core_run high cycles", ran, len);
    axi_read(reg_ctrl, ctrl_word(1'b0, 1'b1, 1'b1));
    axi_read(reg_ctrl, ctrl_word(1'b0, 1'b0, 1'b1)); // done cleared by the first read
  endtask

  task automatic translate_both_channels();
    ptr_model[0] = {$random(seed), 32'hffff_f000 | ($random(seed) & 32'hfff)};
    ptr_model[1] = {32'hffff_ffff, $random(seed) | 32'hf000_0000}; // wraps past 2^64
    axi_write(reg_ptr0_lo, ptr_model[0][31:0], 4'hf);
    axi_write(reg_ptr0_hi, ptr_model[0][63:32], 4'hf);
    axi_write(reg_ptr1_lo, ptr_model[1][31:0], 4'hf);
    axi_write(reg_ptr1_hi, ptr_model[1][63:32], 4'hf);
    for (int n = 0; n < n_xlat; n++) begin
      for (int p = 0; p < 4; p++) send_local(p, rand_local_addr());
    end
    compare_host_addrs();
  endtask

  task automatic stall_host_side();
    logic [local_addr_w-1:0] a1;
    logic [local_addr_w-1:0] a2;
    logic [63:0] held;
    a1 = rand_local_addr();
    a2 = rand_local_addr();
    @(posedge ap_clk);
    c0_awready <= 1'b0;
    send_local(0, a1);
    @(negedge ap_clk);
    held = c0_awaddr;
    fork
      send_local(0, a2);
      begin
        repeat (hold_cycles) begin
          @(negedge ap_clk);
          expect_eq("c0_awvalid", c0_awvalid, 1'b1);
          expect_eq("c0_awaddr", c0_awaddr, held);
          expect_eq("c0_aw_local_ready", c0_aw_local_ready, 1'b0);
        end
        @(posedge ap_clk);
        c0_awready <= 1'b1;
      end
    join
    compare_host_addrs();
  endtask

  initial begin
    ap_rst_n              <= 1'b0;
    s_axi_control_awvalid <= 1'b0;
    s_axi_control_awaddr  <= '0;
    s_axi_control_wvalid  <= 1'b0;
    s_axi_control_wdata   <= '0;
    s_axi_control_wstrb   <= '0;
    s_axi_control_bready  <= 1'b0;
    s_axi_control_arvalid <= 1'b0;
    s_axi_control_araddr  <= '0;
    s_axi_control_rready  <= 1'b0;
    for (int p = 0; p < 4; p++) drive_local(p, 1'b0, '0);
    c0_awready <= 1'b1; // host side always accepting unless a test says otherwise
    c0_arready <= 1'b1;
    c1_awready <= 1'b1;
    c1_arready <= 1'b1;
    repeat (reset_cycles) @(posedge ap_clk);
    ap_rst_n <= 1'b1;
    check_reset_values();
    access_registers();
    time_one_run();
    translate_both_channels();
    stall_host_side();
    $display("Simulation passed");
    $finish;
  end

endmodule

/* design/kvs_shell_top.sv */
`timescale 1ns/100ps

module kvs_shell_top (
  input  logic                                  ap_clk,
  input  logic                                  ap_rst_n,
  // control slave
  input  logic                                  s_axi_control_awvalid,
  output logic                                  s_axi_control_awready,
  input  logic [kvs_ctrl_pkg::ctrl_addr_w-1:0]  s_axi_control_awaddr,
  input  logic                                  s_axi_control_wvalid,
  output logic                                  s_axi_control_wready,
  input  logic [kvs_ctrl_pkg::ctrl_data_w-1:0]  s_axi_control_wdata,
  input  logic [kvs_ctrl_pkg::ctrl_strb_w-1:0]  s_axi_control_wstrb,
  output logic                                  s_axi_control_bvalid,
  input  logic                                  s_axi_control_bready,
  output logic [1:0]                            s_axi_control_bresp,
  input  logic                                  s_axi_control_arvalid,
  output logic                                  s_axi_control_arready,
  input  logic [kvs_ctrl_pkg::ctrl_addr_w-1:0]  s_axi_control_araddr,
  output logic                                  s_axi_control_rvalid,
  input  logic                                  s_axi_control_rready,
  output logic [kvs_ctrl_pkg::ctrl_data_w-1:0]  s_axi_control_rdata,
  output logic [1:0]                            s_axi_control_rresp,
  // channel c0
  input  logic                                  c0_aw_local_valid,
  output logic                                  c0_aw_local_ready,
  input  logic [kvs_mem_pkg::local_addr_w-1:0]  c0_aw_local_addr,
  input  logic                                  c0_ar_local_valid,
  output logic                                  c0_ar_local_ready,
  input  logic [kvs_mem_pkg::local_addr_w-1:0]  c0_ar_local_addr,
  output logic                                  c0_awvalid,
  input  logic                                  c0_awready,
  output logic [kvs_mem_pkg::host_addr_w-1:0]   c0_awaddr,
  output logic                                  c0_arvalid,
  input  logic                                  c0_arready,
  output logic [kvs_mem_pkg::host_addr_w-1:0]   c0_araddr,
  // channel c1
  input  logic                                  c1_aw_local_valid,
  output logic                                  c1_aw_local_ready,
  input  logic [kvs_mem_pkg::local_addr_w-1:0]  c1_aw_local_addr,
  input  logic                                  c1_ar_local_valid,
  output logic                                  c1_ar_local_ready,
  input  logic [kvs_mem_pkg::local_addr_w-1:0]  c1_ar_local_addr,
  output logic                                  c1_awvalid,
  input  logic                                  c1_awready,
  output logic [kvs_mem_pkg::host_addr_w-1:0]   c1_awaddr,
  output logic                                  c1_arvalid,
  input  logic                                  c1_arready,
  output logic [kvs_mem_pkg::host_addr_w-1:0]   c1_araddr,
  output logic                                  core_run // core out of reset
);
  import kvs_ctrl_pkg::*;
  import kvs_mem_pkg::*;

  logic                   ap_start;
  logic                   ap_done;
  logic                   ap_idle;
  logic [cycle_cnt_w-1:0] time_in_cycles;
  host_ptr_u              ptr0;
  host_ptr_u              ptr1;

  ctrl_regs ctrl_regs_inst (
    .ap_clk, .ap_rst_n,
    .s_axi_control_awvalid, .s_axi_control_awready, .s_axi_control_awaddr,
    .s_axi_control_wvalid, .s_axi_control_wready, .s_axi_control_wdata,
    .s_axi_control_wstrb,
    .s_axi_control_bvalid, .s_axi_control_bready, .s_axi_control_bresp,
    .s_axi_control_arvalid, .s_axi_control_arready, .s_axi_control_araddr,
    .s_axi_control_rvalid, .s_axi_control_rready, .s_axi_control_rdata,
    .s_axi_control_rresp,
    .ap_done, .ap_idle, .ap_start, .time_in_cycles, .ptr0, .ptr1
  );

  run_control run_control_inst (
    .ap_clk, .ap_rst_n, .ap_start, .time_in_cycles, .core_run, .ap_done, .ap_idle
  );

  ////////////////////////////////////////////////////////////
  // per-channel address rebasing
  ////////////////////////////////////////////////////////////

  addr_translate c0_translate (
    .ap_clk, .ap_rst_n,
    .base_ptr       (ptr0),
    .aw_local_valid (c0_aw_local_valid),
    .aw_local_ready (c0_aw_local_ready),
    .aw_local_addr  (c0_aw_local_addr),
    .ar_local_valid (c0_ar_local_valid),
    .ar_local_ready (c0_ar_local_ready),
    .ar_local_addr  (c0_ar_local_addr),
    .awvalid        (c0_awvalid),
    .awready        (c0_awready),
    .awaddr         (c0_awaddr),
    .arvalid        (c0_arvalid),
    .arready        (c0_arready),
    .araddr         (c0_araddr)
  );

  addr_translate c1_translate (
    .ap_clk, .ap_rst_n,
    .base_ptr       (ptr1),
    .aw_local_valid (c1_aw_local_valid),
    .aw_local_ready (c1_aw_local_ready),
    .aw_local_addr  (c1_aw_local_addr),
    .ar_local_valid (c1_ar_local_valid),
    .ar_local_ready (c1_ar_local_ready),
    .ar_local_addr  (c1_ar_local_addr),
    .awvalid        (c1_awvalid),
    .awready        (c1_awready),
    .awaddr         (c1_awaddr),
    .arvalid        (c1_arvalid),
    .arready        (c1_arready),
    .araddr         (c1_araddr)
  );

endmodule

/* design/addr_translate.sv */
`timescale 1ns/100ps

module addr_translate (
  input  logic                                  ap_clk,
  input  logic                                  ap_rst_n,
  input  kvs_mem_pkg::host_ptr_u                base_ptr,
  input  logic                                  aw_local_valid,
  output logic                                  aw_local_ready,
  input  logic [kvs_mem_pkg::local_addr_w-1:0]  aw_local_addr,
  input  logic                                  ar_local_valid,
  output logic                                  ar_local_ready,
  input  logic [kvs_mem_pkg::local_addr_w-1:0]  ar_local_addr,
  output logic                                  awvalid,
  input  logic                                  awready,
  output logic [kvs_mem_pkg::host_addr_w-1:0]   awaddr,
  output logic                                  arvalid,
  input  logic                                  arready,
  output logic [kvs_mem_pkg::host_addr_w-1:0]   araddr
);
  import kvs_mem_pkg::*;

  // index 0 is the write-address path, 1 the read-address path
  logic [1:0]              local_valid;
  logic [1:0]              local_ready;
  logic [1:0]              host_ready;
  logic [1:0]              host_valid_q;
  logic [local_addr_w-1:0] local_addr [2];
  logic [host_addr_w-1:0]  host_addr_q [2];

  assign local_valid   = {ar_local_valid, aw_local_valid};
  assign host_ready    = {arready, awready};
  assign local_addr[0] = aw_local_addr;
  assign local_addr[1] = ar_local_addr;

  ////////////////////////////////////////////////////////////
  // one-entry slices
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : g_slice
    // refill in the same cycle the host drains the entry
    assign local_ready[i] = ~host_valid_q[i] | host_ready[i];

    always_ff @(posedge ap_clk) begin
      if (!ap_rst_n) begin
        host_valid_q[i] <= 1'b0;
      end else if (local_ready[i]) begin
        host_valid_q[i] <= local_valid[i];
      end
    end

    // base sampled at the local transfer and wrapped at 2^64
    always_ff @(posedge ap_clk) begin
      if (local_valid[i] && local_ready[i]) begin
        host_addr_q[i] <= base_ptr.full + host_addr_w'(local_addr[i]);
      end
    end

    host_hold_a: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
      host_valid_q[i] && !host_ready[i] |=> host_valid_q[i] && $stable(host_addr_q[i]));
  end

  assign aw_local_ready = local_ready[0];
  assign ar_local_ready = local_ready[1];
  assign awvalid        = host_valid_q[0];
  assign arvalid        = host_valid_q[1];
  assign awaddr         = host_addr_q[0];
  assign araddr         = host_addr_q[1];

endmodule

/* design/run_control.sv */
`timescale 1ns/100ps

module run_control (
  input  logic                                 ap_clk,
  input  logic                                 ap_rst_n,
  input  logic                                 ap_start,
  input  logic [kvs_ctrl_pkg::cycle_cnt_w-1:0] time_in_cycles,
  output logic                                 core_run,
  output logic                                 ap_done,
  output logic                                 ap_idle
);
  import kvs_ctrl_pkg::*;

  logic                   start_q;   // ap_start one cycle late
  logic                   run_q;
  logic [cycle_cnt_w-1:0] remain_q;  // cycles left including the current one
  logic                   start_edge;

  assign start_edge = ap_start & ~start_q;

  ////////////////////////////////////////////////////////////
  // run timer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_q  <= 1'b0;
      run_q    <= 1'b0;
      remain_q <= '0;
    end else begin
      start_q <= ap_start;
      if (start_edge && !run_q) begin
        run_q    <= 1'b1; // core comes out of reset next cycle
        remain_q <= time_in_cycles;
      end else if (run_q) begin
        remain_q <= remain_q - 1'b1;
        if (ap_done) begin
          run_q <= 1'b0;
        end
      end
    end
  end

  // done in the last run cycle and idle again right after it
  assign ap_done  = run_q && remain_q == cycle_cnt_w'(1);
  assign core_run = run_q;
  assign ap_idle  = ~run_q;

  done_ends_run_a: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ap_done |-> core_run ##1 (ap_idle && !core_run));

endmodule

/* design/ctrl_regs.sv */
`timescale 1ns/100ps

module ctrl_regs (
  input  logic                                   ap_clk,
  input  logic                                   ap_rst_n,
  input  logic                                   s_axi_control_awvalid,
  output logic                                   s_axi_control_awready,
  input  logic [kvs_ctrl_pkg::ctrl_addr_w-1:0]   s_axi_control_awaddr,
  input  logic                                   s_axi_control_wvalid,
  output logic                                   s_axi_control_wready,
  input  logic [kvs_ctrl_pkg::ctrl_data_w-1:0]   s_axi_control_wdata,
  input  logic [kvs_ctrl_pkg::ctrl_strb_w-1:0]   s_axi_control_wstrb,
  output logic                                   s_axi_control_bvalid,
  input  logic                                   s_axi_control_bready,
  output logic [1:0]                             s_axi_control_bresp,
  input  logic                                   s_axi_control_arvalid,
  output logic                                   s_axi_control_arready,
  input  logic [kvs_ctrl_pkg::ctrl_addr_w-1:0]   s_axi_control_araddr,
  output logic                                   s_axi_control_rvalid,
  input  logic                                   s_axi_control_rready,
  output logic [kvs_ctrl_pkg::ctrl_data_w-1:0]   s_axi_control_rdata,
  output logic [1:0]                             s_axi_control_rresp,
  input  logic                                   ap_done,
  input  logic                                   ap_idle,
  output logic                                   ap_start,
  output logic [kvs_ctrl_pkg::cycle_cnt_w-1:0]   time_in_cycles,
  output kvs_mem_pkg::host_ptr_u                 ptr0,
  output kvs_mem_pkg::host_ptr_u                 ptr1
);
  import kvs_ctrl_pkg::*;
  import kvs_mem_pkg::*;

  logic                   bvalid_q;
  logic                   rvalid_q;
  logic [ctrl_data_w-1:0] rdata_q;
  logic [ctrl_data_w-1:0] rd_mux;
  logic [cycle_cnt_w-1:0] cycles_q;
  host_ptr_u              ptr0_q;
  host_ptr_u              ptr1_q;
  logic                   start_q;
  logic                   done_q; // sticky until reg_ctrl is read
  logic                   wr_fire;
  logic                   rd_fire;

  // old register word with the strobed byte lanes replaced
  function automatic logic [ctrl_data_w-1:0] merge_strb(input logic [ctrl_data_w-1:0] cur);
    logic [ctrl_data_w-1:0] res;
    res = cur;
    for (int b = 0; b < ctrl_strb_w; b++) begin
      if (s_axi_control_wstrb[b]) begin
        res[8*b +: 8] = s_axi_control_wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // write channel
  ////////////////////////////////////////////////////////////

  assign s_axi_control_awready = ~bvalid_q; // no new write while a response waits
  assign s_axi_control_wready  = ~bvalid_q;
  assign wr_fire = s_axi_control_awvalid & s_axi_control_wvalid & ~bvalid_q;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (s_axi_control_bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      cycles_q <= '0;
      ptr0_q   <= '0;
      ptr1_q   <= '0;
    end else if (wr_fire) begin
      case (s_axi_control_awaddr)
        reg_cycles_lo: cycles_q[31:0]  <= merge_strb(cycles_q[31:0]);
        reg_cycles_hi: cycles_q[63:32] <= merge_strb(cycles_q[63:32]);
        reg_ptr0_lo:   ptr0_q.half.lo  <= merge_strb(ptr0_q.half.lo);
        reg_ptr0_hi:   ptr0_q.half.hi  <= merge_strb(ptr0_q.half.hi);
        reg_ptr1_lo:   ptr1_q.half.lo  <= merge_strb(ptr1_q.half.lo);
        reg_ptr1_hi:   ptr1_q.half.hi  <= merge_strb(ptr1_q.half.hi);
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // start / done bits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      // start taken only from a quiet kernel
      if (wr_fire && s_axi_control_awaddr == reg_ctrl && s_axi_control_wstrb[0] &&
          s_axi_control_wdata[ctrl_start_bit] && ap_idle && !start_q) begin
        start_q <= 1'b1;
      end
      if (rd_fire && s_axi_control_araddr == reg_ctrl) begin
        done_q <= 1'b0;
      end
      if (ap_done) begin // a new done wins over a clearing read
        start_q <= 1'b0;
        done_q  <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////////////////

  assign s_axi_control_arready = ~rvalid_q;
  assign rd_fire = s_axi_control_arvalid & ~rvalid_q;

  always_comb begin
    rd_mux = '0; // unmapped offsets read zero
    case (s_axi_control_araddr)
      reg_ctrl: begin
        rd_mux[ctrl_start_bit] = start_q;
        rd_mux[ctrl_done_bit]  = done_q;
        rd_mux[ctrl_idle_bit]  = ap_idle;
      end
      reg_cycles_lo: rd_mux = cycles_q[31:0];
      reg_cycles_hi: rd_mux = cycles_q[63:32];
      reg_ptr0_lo:   rd_mux = ptr0_q.half.lo;
      reg_ptr0_hi:   rd_mux = ptr0_q.half.hi;
      reg_ptr1_lo:   rd_mux = ptr1_q.half.lo;
      reg_ptr1_hi:   rd_mux = ptr1_q.half.hi;
      default: ;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (s_axi_control_rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (rd_fire) begin
      rdata_q <= rd_mux;
    end
  end

  assign s_axi_control_bvalid = bvalid_q;
  assign s_axi_control_bresp  = resp_okay;
  assign s_axi_control_rvalid = rvalid_q;
  assign s_axi_control_rdata  = rdata_q;
  assign s_axi_control_rresp  = resp_okay;
  assign ap_start       = start_q;
  assign time_in_cycles = cycles_q;
  assign ptr0           = ptr0_q;
  assign ptr1           = ptr1_q;

  // responses stay up until the master takes them
  bvalid_hold_a: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    s_axi_control_bvalid && !s_axi_control_bready |=> s_axi_control_bvalid);
  rvalid_hold_a: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    s_axi_control_rvalid && !s_axi_control_rready |=>
      s_axi_control_rvalid && $stable(s_axi_control_rdata));

endmodule

/* design/kvs_mem_pkg.sv */
package kvs_mem_pkg;

  ////////////////////////////////////////////////////////////
  // memory channel address widths
  ////////////////////////////////////////////////////////////

  localparam int local_addr_w = 34; // as issued by the data movers
  localparam int host_addr_w  = 64;

  // host base pointer
  // the register file fills it as two 32-bit halves, the
  // translators add it as a single 64-bit word
  typedef union packed {
    logic [host_addr_w-1:0] full;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } half;
  } host_ptr_u;

endpackage

/* design/kvs_ctrl_pkg.sv */
package kvs_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // control bus geometry
  ////////////////////////////////////////////////////////////

  localparam int ctrl_addr_w = 12;
  localparam int ctrl_data_w = 32;
  localparam int ctrl_strb_w = ctrl_data_w / 8; // one strobe per byte lane

  // the only AXI response code this slave ever returns
  localparam logic [1:0] resp_okay = 2'b00;

  ////////////////////////////////////////////////////////////
  // register map in byte offsets
  ////////////////////////////////////////////////////////////

  localparam logic [ctrl_addr_w-1:0] reg_ctrl      = 12'h000; // start, done, idle
  localparam logic [ctrl_addr_w-1:0] reg_cycles_lo = 12'h010;
  localparam logic [ctrl_addr_w-1:0] reg_cycles_hi = 12'h014;
  localparam logic [ctrl_addr_w-1:0] reg_ptr0_lo   = 12'h018; // channel c0 base
  localparam logic [ctrl_addr_w-1:0] reg_ptr0_hi   = 12'h01c;
  localparam logic [ctrl_addr_w-1:0] reg_ptr1_lo   = 12'h020; // channel c1 base
  localparam logic [ctrl_addr_w-1:0] reg_ptr1_hi   = 12'h024;

  // bit positions inside reg_ctrl
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_done_bit  = 1; // sticky until a read of reg_ctrl
  localparam int ctrl_idle_bit  = 2;

  // run length split over the two cycle registers
  localparam int cycle_cnt_w = 64;

endpackage
